//--- include/gnn_defs.svh
`ifndef GNN_DEFS_SVH
`define GNN_DEFS_SVH

// weights per sram line, one multiplier each
`define LANES          4

// weight and feature lane width
`define WEIGHT_W       16

// feature count and layer limits
`define MAX_FV         256
`define MAX_LAYERS     4

// weight sram geometry
`define SRAM_WORDS     256
`define SRAM_BW        64

// result stage sizing
`define RESULT_CREDITS 4
`define FIFO_DEPTH     4

`endif

//--- rtl/gnn_pkg.sv
`include "gnn_defs.svh"

package gnn_pkg;

    typedef logic [`WEIGHT_W-1:0] weight_t;
    typedef logic [31:0] psum_t;
    typedef logic [$clog2(`MAX_LAYERS)-1:0] layer_idx_t;
    typedef logic [$clog2(`SRAM_WORDS/`MAX_LAYERS)-1:0] line_idx_t;

    // {layer, line}
    typedef logic [$clog2(`SRAM_WORDS)-1:0] sram_addr_t;
    typedef logic [$clog2(`MAX_FV):0] fv_count_t;
    typedef logic [`SRAM_BW-1:0] sram_word_t;

    typedef enum logic [1:0] {
        cntl_idle,
        cntl_prepare,
        cntl_work
    } cntl_state_t;

    // enables are active low
    typedef struct packed {
        logic       cen;
        logic       wen;
        sram_addr_t addr;
        sram_word_t data;
    } sram_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     last_of_layer;
        layer_idx_t               layer;
        weight_t [`LANES-1:0]     lanes;
    } weight_beat_t;

    typedef struct packed {
        layer_idx_t layer;
        psum_t      sum;
    } result_t;

endpackage

//--- rtl/weight_rx.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module weight_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                sos,
    input  logic                eos,
    input  logic                weight_bit,
    output logic                word_valid,
    output gnn_pkg::sram_word_t word,
    output logic                frame_open
);

    logic       open_q;
    logic [5:0] bit_cnt;
    logic       shift_en;

    // frame counts as open from the sos cycle itself
    assign frame_open = sos || open_q;

    // no data bit travels with eos
    assign shift_en = open_q && !eos && !sos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            open_q     <= 1'b0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            // full word sits in the shift register one cycle after its 64th bit
            word_valid <= shift_en && (bit_cnt == 6'(`SRAM_BW - 1));
            if (sos) begin
                open_q  <= 1'b1;
                bit_cnt <= '0;
            end else begin
                if (eos) begin
                    open_q <= 1'b0;
                end
                if (shift_en) begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end
        end
    end

    // lsb first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (sos) begin
            word <= '0;
        end else if (shift_en) begin
            word <= {weight_bit, word[`SRAM_BW-1:1]};
        end
    end

endmodule

//--- rtl/weight_sram.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module weight_sram (
    input  logic                clk,
    input  gnn_pkg::sram_req_t  req,
    output gnn_pkg::sram_word_t q
);

    gnn_pkg::sram_word_t mem [`SRAM_WORDS];

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (!req.cen) begin
            if (!req.wen) begin
                mem[req.addr] <= req.data;
            end else begin
                q <= mem[req.addr];
            end
        end
    end

endmodule

//--- rtl/weight_cntl.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module weight_cntl (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  frame_open,
    input  logic                                  eos,
    input  logic                                  word_valid,
    input  gnn_pkg::sram_word_t                   word,
    input  logic                                  fire,
    input  gnn_pkg::layer_idx_t                   num_layers,
    input  gnn_pkg::fv_count_t                    num_fv,
    input  logic [$clog2(`FIFO_DEPTH+1)-1:0]      free_slots,
    output logic                                  ready,
    output gnn_pkg::sram_req_t                    sram_req,
    input  gnn_pkg::sram_word_t                   sram_q,
    output gnn_pkg::weight_beat_t                 beat
);

    localparam int SLOT_W = $clog2(`FIFO_DEPTH + 1);

    gnn_pkg::cntl_state_t state, state_n;
    gnn_pkg::sram_addr_t  wr_addr;
    gnn_pkg::layer_idx_t  cur_layer, layers_q;
    gnn_pkg::line_idx_t   cur_line, last_line_q;

    // read issue for this cycle
    logic                 issue, line_end, pass_end, drained;
    gnn_pkg::layer_idx_t  iss_layer, iss_layers;
    gnn_pkg::line_idx_t   iss_line, iss_last_line;
    gnn_pkg::sram_req_t   req_n;

    // beat tag, follows the read through the sram
    logic                 rd_valid, rd_last;
    gnn_pkg::layer_idx_t  rd_layer;
    logic                 q_valid, q_last;
    gnn_pkg::layer_idx_t  q_layer;
    logic                 push_pending;

    // results still in flight are not yet in free_slots
    assign drained = !rd_valid && !q_valid && !beat.valid && !push_pending;

    assign ready = (state == gnn_pkg::cntl_idle) && !frame_open && drained &&
                   (free_slots >= SLOT_W'(num_layers) + SLOT_W'(1));

    always_comb begin
        state_n       = state;
        issue         = 1'b0;
        iss_layer     = cur_layer;
        iss_line      = cur_line;
        iss_layers    = layers_q;
        iss_last_line = last_line_q;
        req_n         = '{cen: 1'b1, wen: 1'b1, addr: wr_addr, data: word};
        case (state)
            gnn_pkg::cntl_idle: begin
                if (frame_open) begin
                    state_n = gnn_pkg::cntl_prepare;
                end else if (fire && ready) begin
                    // first read goes out straight from idle
                    issue         = 1'b1;
                    iss_layer     = '0;
                    iss_line      = '0;
                    iss_layers    = num_layers;
                    iss_last_line = gnn_pkg::line_idx_t'((num_fv - 9'd4) >> 2);
                end
            end
            gnn_pkg::cntl_prepare: begin
                if (word_valid) begin
                    req_n.cen = 1'b0;
                    req_n.wen = 1'b0;
                end
                if (eos) begin
                    state_n = gnn_pkg::cntl_idle;
                end
            end
            gnn_pkg::cntl_work: begin
                issue = 1'b1;
            end
            default: begin
                state_n = gnn_pkg::cntl_idle;
            end
        endcase

        line_end = (iss_line == iss_last_line);
        pass_end = line_end && (iss_layer == iss_layers);
        if (issue) begin
            req_n.cen  = 1'b0;
            req_n.addr = {iss_layer, iss_line};
            state_n    = pass_end ? gnn_pkg::cntl_idle : gnn_pkg::cntl_work;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= gnn_pkg::cntl_idle;
            wr_addr      <= '0;
            cur_layer    <= '0;
            cur_line     <= '0;
            layers_q     <= '0;
            last_line_q  <= '0;
            sram_req     <= '{cen: 1'b1, wen: 1'b1, default: '0};
            rd_valid     <= 1'b0;
            rd_last      <= 1'b0;
            rd_layer     <= '0;
            q_valid      <= 1'b0;
            q_last       <= 1'b0;
            q_layer      <= '0;
            beat         <= '0;
            push_pending <= 1'b0;
        end else begin
            state    <= state_n;
            sram_req <= req_n;

            // every frame loads from address 0
            if (state == gnn_pkg::cntl_idle && frame_open) begin
                wr_addr <= '0;
            end else if (state == gnn_pkg::cntl_prepare && word_valid) begin
                wr_addr <= wr_addr + 1'b1;
            end

            if (issue) begin
                layers_q    <= iss_layers;
                last_line_q <= iss_last_line;
                cur_line    <= line_end ? '0 : iss_line + 1'b1;
                cur_layer   <= line_end ? iss_layer + 1'b1 : iss_layer;
            end

            rd_valid <= issue;
            rd_last  <= issue && line_end;
            rd_layer <= iss_layer;

            // lines up with sram_q
            q_valid <= rd_valid;
            q_last  <= rd_last;
            q_layer <= rd_layer;

            beat.valid         <= q_valid;
            beat.last_of_layer <= q_last;
            beat.layer         <= q_layer;
            beat.lanes         <= sram_q;

            push_pending <= beat.valid && beat.last_of_layer;
        end
    end

endmodule

//--- rtl/vertex_mac.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module vertex_mac (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              fire,
    input  gnn_pkg::weight_t [`LANES-1:0]     feat_in,
    input  gnn_pkg::weight_beat_t             beat,
    output logic                              result_push,
    output gnn_pkg::result_t                  result
);

    gnn_pkg::weight_t [`LANES-1:0] feat_q;
    gnn_pkg::psum_t   [`LANES-1:0] prod;
    gnn_pkg::psum_t                sum_lo;
    gnn_pkg::psum_t                sum_hi;
    gnn_pkg::psum_t                beat_sum;
    gnn_pkg::psum_t                acc;

    // features stay put for the whole pass
    always_ff @(posedge clk) begin
        if (fire) begin
            feat_q <= feat_in;
        end
    end

    // unsigned products, 16x16 fits in 32
    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            prod[i] = gnn_pkg::psum_t'(beat.lanes[i]) * gnn_pkg::psum_t'(feat_q[i]);
        end
    end

    // two level adder tree
    assign sum_lo   = prod[0] + prod[1];
    assign sum_hi   = prod[2] + prod[3];
    assign beat_sum = sum_lo + sum_hi;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            acc         <= '0;
            result_push <= 1'b0;
        end else begin
            result_push <= beat.valid && beat.last_of_layer;
            if (beat.valid) begin
                // layer end restarts the sum for the next layer
                acc <= beat.last_of_layer ? '0 : acc + beat_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid && beat.last_of_layer) begin
            result.layer <= beat.layer;
            result.sum   <= acc + beat_sum;
        end
    end

endmodule

//--- rtl/result_out.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module result_out (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              push,
    input  gnn_pkg::result_t                  result_in,
    input  logic                              credit_return,
    output logic [$clog2(`FIFO_DEPTH+1)-1:0]  free_slots,
    output logic                              result_valid,
    output gnn_pkg::result_t                  result
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(`RESULT_CREDITS + 1);

    gnn_pkg::result_t   fifo_mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRD_W-1:0]   credits;
    logic               send;

    // one result per credit
    assign send       = (count != '0) && (credits != '0);
    assign free_slots = CNT_W'(`FIFO_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= result_in;
        end
        if (send) begin
            result <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= CRD_W'(`RESULT_CREDITS);
            result_valid <= 1'b0;
        end else begin
            result_valid <= send;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(push) - CNT_W'(send);
            credits <= credits + CRD_W'(credit_return) - CRD_W'(send);
        end
    end

endmodule

//--- rtl/gnn_pe_top.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module gnn_pe_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              sos,
    input  logic                              eos,
    input  logic                              weight_bit,
    input  logic                              fire,
    input  gnn_pkg::layer_idx_t               num_layers,
    input  gnn_pkg::fv_count_t                num_fv,
    input  gnn_pkg::weight_t [`LANES-1:0]     feat_in,
    output logic                              ready,
    input  logic                              credit_return,
    output logic                              result_valid,
    output gnn_pkg::result_t                  result
);

    logic                                 word_valid;
    gnn_pkg::sram_word_t                  word;
    logic                                 frame_open;
    gnn_pkg::sram_req_t                   sram_req;
    gnn_pkg::sram_word_t                  sram_q;
    gnn_pkg::weight_beat_t                beat;
    logic [$clog2(`FIFO_DEPTH+1)-1:0]     free_slots;
    logic                                 result_push;
    gnn_pkg::result_t                     mac_result;

    weight_rx u_weight_rx (
        .clk        (clk),
        .reset      (reset),
        .sos        (sos),
        .eos        (eos),
        .weight_bit (weight_bit),
        .word_valid (word_valid),
        .word       (word),
        .frame_open (frame_open)
    );

    weight_sram u_weight_sram (
        .clk (clk),
        .req (sram_req),
        .q   (sram_q)
    );

    weight_cntl u_weight_cntl (
        .clk        (clk),
        .reset      (reset),
        .frame_open (frame_open),
        .eos        (eos),
        .word_valid (word_valid),
        .word       (word),
        .fire       (fire),
        .num_layers (num_layers),
        .num_fv     (num_fv),
        .free_slots (free_slots),
        .ready      (ready),
        .sram_req   (sram_req),
        .sram_q     (sram_q),
        .beat       (beat)
    );

    // features latch only on an accepted fire
    vertex_mac u_vertex_mac (
        .clk         (clk),
        .reset       (reset),
        .fire        (fire & ready),
        .feat_in     (feat_in),
        .beat        (beat),
        .result_push (result_push),
        .result      (mac_result)
    );

    result_out u_result_out (
        .clk           (clk),
        .reset         (reset),
        .push          (result_push),
        .result_in     (mac_result),
        .credit_return (credit_return),
        .free_slots    (free_slots),
        .result_valid  (result_valid),
        .result        (result)
    );

endmodule

//--- testbench/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low over three rising edges
    initial begin
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b1;
    end

endmodule

//--- testbench/gnn_pe_asserts.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module gnn_pe_asserts (
    input logic                             clk,
    input logic                             reset,
    input logic                             sos,
    input logic                             eos,
    input logic                             result_valid,
    input logic                             credit_return,
    input logic                             ready,
    input logic [$clog2(`FIFO_DEPTH+1)-1:0] free_slots
);

    int   avail;
    int   fail_cnt = 0;
    logic in_frame;

    // credit count of the result stage seen from its ports
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            avail <= `RESULT_CREDITS;
        end else begin
            avail <= avail + int'(credit_return) - int'(result_valid);
        end
    end

    // frame runs from the sos pulse through the eos cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_frame <= 1'b0;
        end else if (sos) begin
            in_frame <= 1'b1;
        end else if (eos) begin
            in_frame <= 1'b0;
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (!reset) result_valid |-> avail > 0)
        else begin
            $error("result sent with no credit left");
            fail_cnt++;
        end

    a_reset: assert property (@(posedge clk) !reset |-> !result_valid)
        else begin
            $error("result_valid high during reset");
            fail_cnt++;
        end

    a_frame: assert property (@(posedge clk) disable iff (!reset)
                              (sos || in_frame) |-> !ready)
        else begin
            $error("ready high while a weight frame is open");
            fail_cnt++;
        end

    a_slots: assert property (@(posedge clk) disable iff (!reset) free_slots <= `FIFO_DEPTH)
        else begin
            $error("free_slots above fifo depth");
            fail_cnt++;
        end

endmodule

//--- testbench/tb_gnn_pe.sv
`timescale 1ns/10ps
`include "gnn_defs.svh"

module tb_gnn_pe;

    // word loads of all tests plus eight passes with their waits
    localparam int LOAD_CYCLES    = (16 + 256 + 16 + 80) * (`SRAM_BW + 8);
    localparam int TIMEOUT_CYCLES = 2 * (LOAD_CYCLES + 8 * 300);

    logic clk, reset, sos, eos, weight_bit, fire, ready;
    logic credit_return, result_valid;
    gnn_pkg::layer_idx_t           num_layers;
    gnn_pkg::fv_count_t            num_fv;
    gnn_pkg::weight_t [`LANES-1:0] feat_in;
    gnn_pkg::result_t              result;

    gnn_pkg::sram_word_t wmem [`SRAM_WORDS];
    gnn_pkg::result_t    exp_q [$];
    integer seed = 45915;
    string  test_name = "reset";
    int errors = 0;
    int result_cnt = 0;
    int n_pass = 0;
    int n_fail = 0;
    int err_base = 0;
    int base = 0;
    int cycles = 0;
    int manual_credits = 0;
    logic auto_credit = 1'b1;

    clk_gen u_clk_gen (.clk(clk), .reset(reset));

    gnn_pe_top u_gnn_pe_top (
        .clk           (clk),
        .reset         (reset),
        .sos           (sos),
        .eos           (eos),
        .weight_bit    (weight_bit),
        .fire          (fire),
        .num_layers    (num_layers),
        .num_fv        (num_fv),
        .feat_in       (feat_in),
        .ready         (ready),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result)
    );

    bind gnn_pe_top gnn_pe_asserts u_gnn_pe_asserts (
        .clk           (clk),
        .reset         (reset),
        .sos           (sos),
        .eos           (eos),
        .result_valid  (result_valid),
        .credit_return (credit_return),
        .ready         (ready),
        .free_slots    (free_slots)
    );

    // a credit goes back the cycle after each result or from manual top-ups
    always @(posedge clk) begin
        #2;
        credit_return = (auto_credit && result_valid) || (manual_credits > 0);
        if (manual_credits > 0) begin
            manual_credits--;
        end
    end

    always @(negedge clk) begin : check_result
        gnn_pkg::result_t exp_r;
        if (reset && result_valid) begin
            result_cnt++;
            if (exp_q.size() == 0) begin
                $display("%s: result for layer %0d arrived with none expected",
                         test_name, result.layer);
                errors++;
            end else begin
                exp_r = exp_q.pop_front();
                assert (result == exp_r)
                    else begin
                        $display("mismatch in %s: expected %0d/%08h, actual %0d/%08h",
                                 test_name, exp_r.layer, exp_r.sum, result.layer, result.sum);
                        errors++;
                    end
            end
        end
    end

    function automatic int total_errors();
        return errors + u_gnn_pe_top.u_gnn_pe_asserts.fail_cnt;
    endfunction

    function automatic gnn_pkg::sram_word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // dot products of each line with the features summed over the layer
    function automatic gnn_pkg::psum_t layer_sum(input int layer, input int nlines,
                                                 input gnn_pkg::weight_t [`LANES-1:0] feat);
        gnn_pkg::psum_t      acc;
        gnn_pkg::sram_word_t wline;
        acc = '0;
        for (int l = 0; l < nlines; l++) begin
            wline = wmem[layer * 64 + l];
            for (int i = 0; i < `LANES; i++)
                acc = acc + 32'(wline[16*i +: 16]) * 32'(feat[i]);
        end
        return acc;
    endfunction

    // one frame from address 0 with the lsb of each word first
    task automatic send_weights(input int nwords);
        @(posedge clk);
        #2;
        sos = 1'b1;
        for (int w = 0; w < nwords; w++) begin
            for (int b = 0; b < `SRAM_BW; b++) begin
                @(posedge clk);
                #2;
                sos = 1'b0;
                weight_bit = wmem[w][b];
            end
        end
        @(posedge clk);
        #2;
        eos = 1'b1;
        weight_bit = 1'b0;
        @(posedge clk);
        #2;
        eos = 1'b0;
        repeat (3) @(posedge clk);
        #2;
    endtask

    task automatic run_pass(input int layers, input int nfv);
        gnn_pkg::result_t exp_r;
        int n;
        num_layers = gnn_pkg::layer_idx_t'(layers - 1);
        num_fv = gnn_pkg::fv_count_t'(nfv);
        for (int i = 0; i < `LANES; i++)
            feat_in[i] = 16'($random(seed));
        n = 0;
        @(posedge clk);
        #2;
        while (!ready && n < 300) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ready) begin
            $display("%s: ready stayed low for %0d cycles", test_name, n);
            errors++;
        end else begin
            fire = 1'b1;
            for (int l = 0; l < layers; l++) begin
                exp_r.layer = gnn_pkg::layer_idx_t'(l);
                exp_r.sum = layer_sum(l, nfv / 4, feat_in);
                exp_q.push_back(exp_r);
            end
            @(posedge clk);
            #2;
            fire = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d results missing after %0d cycles", test_name, exp_q.size(), n);
            errors++;
            exp_q.delete();
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic expect_count(input int n);
        assert (result_cnt - base == n)
            else begin
                $display("mismatch in %s: expected %0d results, actual %0d",
                         test_name, n, result_cnt - base);
                errors++;
            end
    endtask

    task automatic spurious_fire();
        fire = 1'b1;
        assert (!ready)
            else begin
                $display("%s: ready high when it should be low", test_name);
                errors++;
            end
        @(posedge clk);
        #2;
        fire = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base = total_errors();
        base = result_cnt;
    endtask

    task automatic end_test();
        if (total_errors() == err_base) begin
            n_pass++;
            $display("test %s: passed", test_name);
        end else begin
            n_fail++;
            $display("test %s: FAILED", test_name);
        end
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles in test %s", cycles, test_name);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        sos = 1'b0;
        eos = 1'b0;
        weight_bit = 1'b0;
        fire = 1'b0;
        credit_return = 1'b0;
        num_layers = '0;
        num_fv = 9'd64;
        feat_in = '0;
        wait (reset === 1'b1);

        start_test("single_layer");
        for (int a = 0; a < 16; a++)
            wmem[a] = rand_word();
        send_weights(16);
        run_pass(1, 64);
        wait_drain();
        expect_count(1);
        end_test();

        start_test("four_layers");
        for (int a = 0; a < `SRAM_WORDS; a++)
            wmem[a] = rand_word();
        send_weights(`SRAM_WORDS);
        run_pass(4, 64);
        wait_drain();
        expect_count(4);
        end_test();

        start_test("backpressure");
        auto_credit = 1'b0;
        run_pass(2, 64);
        run_pass(2, 64);
        wait_drain();
        expect_count(4);
        // third pass parks its two results in the fifo
        run_pass(2, 64);
        repeat (40) @(posedge clk);
        #2;
        num_layers = 2'd3;
        base = result_cnt;
        repeat (20) begin
            @(posedge clk);
            #2;
            spurious_fire();
        end
        expect_count(0);
        @(negedge clk);
        manual_credits = 6;
        wait_drain();
        auto_credit = 1'b1;
        run_pass(4, 64);
        wait_drain();
        expect_count(6);
        end_test();

        start_test("fire_while_busy");
        fork
            send_weights(16);
            begin
                repeat (300) @(posedge clk);
                #2;
                spurious_fire();
            end
        join
        run_pass(1, 64);
        repeat (3) @(posedge clk);
        #2;
        spurious_fire();
        wait_drain();
        repeat (30) @(posedge clk);
        expect_count(1);
        end_test();

        start_test("reload_layer1");
        for (int a = 64; a < 80; a++)
            wmem[a] = rand_word();
        send_weights(80);
        run_pass(2, 64);
        wait_drain();
        expect_count(2);
        end_test();

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
rtl/gnn_pkg.sv
rtl/weight_rx.sv
rtl/weight_sram.sv
rtl/weight_cntl.sv
rtl/vertex_mac.sv
rtl/result_out.sv
rtl/gnn_pe_top.sv
testbench/clk_gen.sv
testbench/gnn_pe_asserts.sv
testbench/tb_gnn_pe.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f src.f --top-module tb_gnn_pe -Mdir obj_dir -o sim_gnn_pe
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_gnn_pe +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0
